// ==== rv_core_pkg.sv ====
package rv_core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_index_t;

	// Major opcodes of the RV32 base encoding that this core decodes.
	typedef enum logic [6:0] {
		op_lui      = 7'b0110111,
		op_auipc    = 7'b0010111,
		op_jal      = 7'b1101111,
		op_jalr     = 7'b1100111,
		op_branch   = 7'b1100011,
		op_load     = 7'b0000011,
		op_store    = 7'b0100011,
		op_imm      = 7'b0010011,
		op_reg      = 7'b0110011,
		op_misc_mem = 7'b0001111,
		op_system   = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		fmt_none,
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} inst_format_e;

	typedef enum logic [3:0] {
		kind_lui,
		kind_auipc,
		kind_jal,
		kind_jalr,
		kind_beq,
		kind_lw,
		kind_sw,
		kind_addi,
		kind_add,
		kind_system,
		kind_fence_i,
		kind_illegal
	} inst_kind_e;

	typedef enum logic [1:0] {
		sys_none,
		sys_ecall,
		sys_mret
	} sys_event_e;

	typedef struct packed {
		inst_kind_e kind;
		word_t      pc;
		reg_index_t rd;
		logic       reg_wen;
		word_t      imm;
		word_t      src1;
		word_t      src2;
		logic [2:0] funct3;
		logic [6:0] funct7;
		sys_event_e sys;
	} decoded_inst_t;

	typedef struct packed {
		logic       is_store;
		word_t      addr;
		word_t      wdata;
		reg_index_t rd;
	} mem_request_t;

	typedef struct packed {
		logic       wen;
		reg_index_t rd;
		word_t      data;
	} writeback_t;

endpackage

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                    clock,
	input  logic                    reset,
	input  rv_core_pkg::reg_index_t rs1,
	input  rv_core_pkg::reg_index_t rs2,
	output rv_core_pkg::word_t      src1,
	output rv_core_pkg::word_t      src2,
	input  rv_core_pkg::writeback_t wb_a,
	input  rv_core_pkg::writeback_t wb_b
);

	rv_core_pkg::word_t regs [16];

	// Port b is checked first so that it wins, matching the write order below.
	function automatic rv_core_pkg::word_t read_port(input rv_core_pkg::reg_index_t idx);
		if (idx == '0) return '0;
		if (wb_b.wen && wb_b.rd == idx) return wb_b.data;
		if (wb_a.wen && wb_a.rd == idx) return wb_a.data;
		return regs[idx];
	endfunction

	always_comb begin
		src1 = read_port(rs1);
		src2 = read_port(rs2);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_a.wen && wb_a.rd != '0) begin
				regs[wb_a.rd] <= wb_a.data;
			end
			if (wb_b.wen && wb_b.rd != '0) begin
				regs[wb_b.rd] <= wb_b.data;
			end
		end
	end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       inst_valid,
	input  rv_core_pkg::word_t         inst,
	input  rv_core_pkg::word_t         pc,
	output logic                       inst_ready,
	output rv_core_pkg::reg_index_t    rs1,
	output rv_core_pkg::reg_index_t    rs2,
	input  rv_core_pkg::word_t         src1,
	input  rv_core_pkg::word_t         src2,
	input  rv_core_pkg::reg_index_t    exu_busy_rd,
	input  logic                       exu_busy_wen,
	input  logic                       exu_ready,
	input  rv_core_pkg::reg_index_t    lsu_busy_rd,
	input  logic                       lsu_busy_wen,
	input  logic                       lsu_ready,
	input  logic                       redirect_valid,
	output logic                       ex_valid,
	output rv_core_pkg::decoded_inst_t ex_inst,
	input  logic                       ex_ready
);

	rv_core_pkg::inst_kind_e   kind;
	rv_core_pkg::inst_format_e format;
	rv_core_pkg::sys_event_e   sys;
	rv_core_pkg::word_t        imm;
	rv_core_pkg::reg_index_t   held_rs1;
	rv_core_pkg::reg_index_t   held_rs2;
	logic                      held_need_rs2;
	logic                      need_rs2;
	logic                      reg_wen;
	logic                      accept;
	logic                      hazard;

	// A busy stage that will still write one of our sources blocks issue.
	function automatic logic conflict(input logic busy, input logic wen,
			input rv_core_pkg::reg_index_t rd);
		return busy & wen & (rd != '0) &
			((rd == held_rs1) | (held_need_rs2 & (rd == held_rs2)));
	endfunction

	always_comb begin
		kind = rv_core_pkg::kind_illegal;
		format = rv_core_pkg::fmt_none;
		sys = rv_core_pkg::sys_none;
		case (inst[6:0])
			rv_core_pkg::op_lui: begin
				kind = rv_core_pkg::kind_lui;
				format = rv_core_pkg::fmt_u;
			end
			rv_core_pkg::op_auipc: begin
				kind = rv_core_pkg::kind_auipc;
				format = rv_core_pkg::fmt_u;
			end
			rv_core_pkg::op_jal: begin
				kind = rv_core_pkg::kind_jal;
				format = rv_core_pkg::fmt_j;
			end
			rv_core_pkg::op_jalr: begin
				kind = rv_core_pkg::kind_jalr;
				format = rv_core_pkg::fmt_i;
			end
			rv_core_pkg::op_branch: if (inst[14:12] == 3'b000) begin
				kind = rv_core_pkg::kind_beq;
				format = rv_core_pkg::fmt_b;
			end
			rv_core_pkg::op_load: if (inst[14:12] == 3'b010) begin
				kind = rv_core_pkg::kind_lw;
				format = rv_core_pkg::fmt_i;
			end
			rv_core_pkg::op_store: if (inst[14:12] == 3'b010) begin
				kind = rv_core_pkg::kind_sw;
				format = rv_core_pkg::fmt_s;
			end
			rv_core_pkg::op_imm: if (inst[14:12] == 3'b000) begin
				kind = rv_core_pkg::kind_addi;
				format = rv_core_pkg::fmt_i;
			end
			rv_core_pkg::op_reg: if (inst[14:12] == 3'b000 && inst[31:25] == 7'b0) begin
				kind = rv_core_pkg::kind_add;
				format = rv_core_pkg::fmt_r;
			end
			rv_core_pkg::op_misc_mem: if (inst[14:12] == 3'b001) begin
				kind = rv_core_pkg::kind_fence_i;
			end
			rv_core_pkg::op_system: begin
				format = rv_core_pkg::fmt_i;
				// Only the exact ECALL and MRET words are supported.
				if (inst == 32'h0000_0073) begin
					kind = rv_core_pkg::kind_system;
					sys = rv_core_pkg::sys_ecall;
				end else if (inst == 32'h3020_0073) begin
					kind = rv_core_pkg::kind_system;
					sys = rv_core_pkg::sys_mret;
				end
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		case (format)
			rv_core_pkg::fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
			rv_core_pkg::fmt_s: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			rv_core_pkg::fmt_b: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			rv_core_pkg::fmt_u: imm = {inst[31:12], 12'b0};
			rv_core_pkg::fmt_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			default: imm = '0;
		endcase
	end

	assign reg_wen = (format == rv_core_pkg::fmt_r || format == rv_core_pkg::fmt_i ||
		format == rv_core_pkg::fmt_u || format == rv_core_pkg::fmt_j) &&
		kind != rv_core_pkg::kind_system && kind != rv_core_pkg::kind_illegal;
	assign need_rs2 = kind == rv_core_pkg::kind_beq || kind == rv_core_pkg::kind_sw ||
		kind == rv_core_pkg::kind_add;

	// While an instruction is held, the register file keeps reading its sources.
	assign rs1 = inst_ready ? inst[18:15] : held_rs1;
	assign rs2 = inst_ready ? inst[23:20] : held_rs2;

	assign accept = inst_valid & inst_ready & ~redirect_valid;
	assign hazard = conflict(~exu_ready, exu_busy_wen, exu_busy_rd) |
		conflict(~lsu_ready, lsu_busy_wen, lsu_busy_rd);
	assign ex_valid = ~inst_ready & ~hazard & ~redirect_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			inst_ready <= 1'b1;
		end else if (redirect_valid) begin
			inst_ready <= 1'b1;
		end else if (inst_ready) begin
			inst_ready <= ~inst_valid;
		end else begin
			inst_ready <= ex_valid & ex_ready;
		end
		if (accept) begin
			ex_inst <= '{kind: kind, pc: pc, rd: inst[10:7], reg_wen: reg_wen, imm: imm,
				src1: src1, src2: src2, funct3: inst[14:12], funct7: inst[31:25], sys: sys};
			held_rs1 <= inst[18:15];
			held_rs2 <= inst[23:20];
			held_need_rs2 <= need_rs2;
		end else if (!inst_ready && !ex_valid) begin
			ex_inst.src1 <= src1;
			ex_inst.src2 <= src2;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		(ex_valid && !ex_ready) |=> $stable(ex_inst));

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       ex_valid,
	input  rv_core_pkg::decoded_inst_t ex_inst,
	output logic                       ex_ready,
	output rv_core_pkg::reg_index_t    busy_rd,
	output logic                       busy_wen,
	output logic                       mem_valid,
	output rv_core_pkg::mem_request_t  mem_req,
	input  logic                       mem_ready,
	input  rv_core_pkg::reg_index_t    pending_load_rd,
	input  logic                       pending_load,
	output rv_core_pkg::writeback_t    exu_wb,
	output logic                       redirect_valid,
	output rv_core_pkg::word_t         redirect_pc,
	output rv_core_pkg::sys_event_e    sys_event
);

	rv_core_pkg::word_t result;
	rv_core_pkg::word_t target;
	rv_core_pkg::word_t sum_imm;
	rv_core_pkg::word_t pc_imm;
	rv_core_pkg::word_t link;
	logic               redirect_next;
	logic               is_mem;
	logic               load_stall;
	logic               take;

	assign is_mem = ex_inst.kind == rv_core_pkg::kind_lw || ex_inst.kind == rv_core_pkg::kind_sw;
	// A register write must not overtake an older load to the same rd.
	assign load_stall = pending_load & ex_inst.reg_wen & ~is_mem & (ex_inst.rd == pending_load_rd);
	assign ex_ready = ~mem_valid & ~load_stall;
	assign take = ex_valid & ex_ready;
	assign busy_rd = mem_req.rd;
	assign busy_wen = mem_valid & ~mem_req.is_store;

	assign sum_imm = ex_inst.src1 + ex_inst.imm;
	assign pc_imm = ex_inst.pc + ex_inst.imm;
	assign link = ex_inst.pc + 32'd4;

	always_comb begin
		result = link;
		target = pc_imm;
		redirect_next = 1'b0;
		case (ex_inst.kind)
			rv_core_pkg::kind_add: result = ex_inst.src1 + ex_inst.src2;
			rv_core_pkg::kind_addi: result = sum_imm;
			rv_core_pkg::kind_lui: result = ex_inst.imm;
			rv_core_pkg::kind_auipc: result = pc_imm;
			rv_core_pkg::kind_jal: redirect_next = 1'b1;
			rv_core_pkg::kind_jalr: begin
				redirect_next = 1'b1;
				target = {sum_imm[31:1], 1'b0};
			end
			rv_core_pkg::kind_beq: begin
				redirect_next = ex_inst.funct3 == 3'b000 && ex_inst.src1 == ex_inst.src2;
			end
			rv_core_pkg::kind_fence_i: begin
				redirect_next = 1'b1;
				target = link;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			exu_wb.wen <= 1'b0;
			redirect_valid <= 1'b0;
			sys_event <= rv_core_pkg::sys_none;
			mem_valid <= 1'b0;
		end else begin
			exu_wb.wen <= take & ex_inst.reg_wen & ~is_mem;
			redirect_valid <= take & redirect_next;
			sys_event <= (take && ex_inst.kind == rv_core_pkg::kind_system) ?
				ex_inst.sys : rv_core_pkg::sys_none;
			if (take && is_mem) begin
				mem_valid <= 1'b1;
			end else if (mem_ready) begin
				mem_valid <= 1'b0;
			end
		end
		if (take) begin
			exu_wb.rd <= ex_inst.rd;
			exu_wb.data <= result;
			redirect_pc <= target;
		end
		if (take && is_mem) begin
			mem_req <= '{is_store: ex_inst.kind == rv_core_pkg::kind_sw, addr: sum_imm,
				wdata: ex_inst.src2, rd: ex_inst.rd};
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		(take && ex_inst.kind == rv_core_pkg::kind_illegal) |=> !redirect_valid && !exu_wb.wen);

endmodule

// ==== load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit #(
	parameter int MEM_WORDS   = 64,
	parameter int MEM_LATENCY = 2
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      mem_valid,
	input  rv_core_pkg::mem_request_t mem_req,
	output logic                      mem_ready,
	output rv_core_pkg::reg_index_t   busy_rd,
	output logic                      busy_wen,
	output rv_core_pkg::writeback_t   lsu_wb,
	output logic                      lsu_done
);

	localparam int ADDR_BITS  = $clog2(MEM_WORDS);
	localparam int COUNT_BITS = $clog2(MEM_LATENCY + 1);

	rv_core_pkg::word_t        mem [MEM_WORDS];
	rv_core_pkg::mem_request_t req;
	logic [COUNT_BITS-1:0]     count;
	logic [ADDR_BITS-1:0]      word_index;
	logic                      accept;

	assign accept = mem_valid & mem_ready;
	assign mem_ready = (count == '0);
	assign lsu_done = (count == COUNT_BITS'(1));
	assign busy_rd = req.rd;
	assign busy_wen = (count != '0) & ~req.is_store;

	// Byte address bits 1:0 are dropped; the word index wraps at the memory depth.
	assign word_index = ADDR_BITS'((req.addr >> 2) % MEM_WORDS);

	assign lsu_wb.wen = lsu_done & ~req.is_store;
	assign lsu_wb.rd = req.rd;
	assign lsu_wb.data = mem[word_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (accept) begin
			count <= COUNT_BITS'(MEM_LATENCY);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
		if (accept) begin
			req <= mem_req;
		end
	end

	// Stores land in the completion cycle, together with their retire.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (lsu_done && req.is_store) begin
			mem[word_index] <= req.wdata;
		end
	end

	// One request in flight; it completes exactly MEM_LATENCY cycles later.
	assert property (@(posedge clock) disable iff (reset)
		accept |-> ##MEM_LATENCY (lsu_done && !accept));

endmodule

// ==== rv_backend_top.sv ====
`timescale 1ns/1ps

module rv_backend_top #(
	parameter int MEM_WORDS   = 64,
	parameter int MEM_LATENCY = 2
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    inst_valid,
	input  rv_core_pkg::word_t      inst,
	input  rv_core_pkg::word_t      pc,
	output logic                    inst_ready,
	output logic                    retire_valid,
	output rv_core_pkg::writeback_t retire,
	output logic                    redirect_valid,
	output rv_core_pkg::word_t      redirect_pc,
	output rv_core_pkg::sys_event_e sys_event
);

	rv_core_pkg::reg_index_t    rs1;
	rv_core_pkg::reg_index_t    rs2;
	rv_core_pkg::word_t         src1;
	rv_core_pkg::word_t         src2;
	rv_core_pkg::decoded_inst_t ex_inst;
	rv_core_pkg::mem_request_t  mem_req;
	rv_core_pkg::writeback_t    exu_wb;
	rv_core_pkg::writeback_t    exu_write;
	rv_core_pkg::writeback_t    lsu_wb;
	rv_core_pkg::writeback_t    held_wb;
	rv_core_pkg::reg_index_t    exu_busy_rd;
	rv_core_pkg::reg_index_t    lsu_busy_rd;
	logic                       exu_busy_wen;
	logic                       lsu_busy_wen;
	logic                       ex_valid;
	logic                       ex_ready;
	logic                       mem_valid;
	logic                       mem_ready;
	logic                       lsu_done;
	logic                       exu_done;
	logic                       held_valid;

	decode_stage i_decode (
		.clock, .reset, .inst_valid, .inst, .pc, .inst_ready, .rs1, .rs2, .src1, .src2,
		.exu_busy_rd, .exu_busy_wen, .exu_ready(ex_ready),
		.lsu_busy_rd, .lsu_busy_wen, .lsu_ready(mem_ready),
		.redirect_valid, .ex_valid, .ex_inst, .ex_ready
	);

	// The load result is the older instruction, so it wins a same-rd collision.
	assign exu_write = '{wen: exu_wb.wen & ~(lsu_wb.wen & (lsu_wb.rd == exu_wb.rd)),
		rd: exu_wb.rd, data: exu_wb.data};

	register_file i_regs (.clock, .reset, .rs1, .rs2, .src1, .src2, .wb_a(exu_write), .wb_b(lsu_wb));

	execute_stage i_execute (
		.clock, .reset, .ex_valid, .ex_inst, .ex_ready,
		.busy_rd(exu_busy_rd), .busy_wen(exu_busy_wen), .mem_valid, .mem_req, .mem_ready,
		.pending_load_rd(lsu_busy_rd), .pending_load(lsu_busy_wen),
		.exu_wb, .redirect_valid, .redirect_pc, .sys_event
	);

	load_store_unit #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) i_lsu (
		.clock, .reset, .mem_valid, .mem_req, .mem_ready,
		.busy_rd(lsu_busy_rd), .busy_wen(lsu_busy_wen), .lsu_wb, .lsu_done
	);

	// Execute completes a non-memory instruction one cycle after taking it.
	// An execute retire that meets a load/store retire waits one cycle in held_wb.
	always_ff @(posedge clock) begin
		if (reset) begin
			exu_done <= 1'b0;
			held_valid <= 1'b0;
		end else begin
			exu_done <= ex_valid & ex_ready & (ex_inst.kind != rv_core_pkg::kind_lw) &
				(ex_inst.kind != rv_core_pkg::kind_sw);
			held_valid <= exu_done & (lsu_done | held_valid);
		end
		if (exu_done) begin
			held_wb <= exu_wb;
		end
	end

	assign retire_valid = lsu_done | held_valid | exu_done;
	assign retire = lsu_done ? lsu_wb : (held_valid ? held_wb : exu_wb);

	assert property (@(posedge clock) disable iff (reset)
		(exu_wb.wen && lsu_wb.wen) |-> (exu_wb.rd != lsu_wb.rd));

endmodule

// ==== tb_rv_backend.sv ====
`timescale 1ns/1ps

module tb_rv_backend;

	localparam int MEM_WORDS = 64;
	localparam int MEM_LATENCY = 2;
	localparam int NUM_TESTS = 28;
	localparam int CLOCK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int WATCHDOG_CYCLES = 4 + NUM_TESTS * (MEM_LATENCY + 8);
	localparam logic [6:0] OP_IMM = 7'h13;
	localparam logic [6:0] OP_REG = 7'h33;
	localparam logic [6:0] OP_LUI = 7'h37;
	localparam logic [6:0] OP_AUIPC = 7'h17;
	localparam logic [6:0] OP_JAL = 7'h6f;
	localparam logic [6:0] OP_JALR = 7'h67;
	localparam logic [6:0] OP_BRANCH = 7'h63;
	localparam logic [6:0] OP_LOAD = 7'h03;
	localparam logic [6:0] OP_STORE = 7'h23;
	localparam rv_core_pkg::sys_event_e SYS_NONE = rv_core_pkg::sys_none;

	typedef struct {
		string                   name;
		rv_core_pkg::word_t      pc;
		rv_core_pkg::word_t      inst;
		logic                    wen;
		rv_core_pkg::reg_index_t rd;
		rv_core_pkg::word_t      data;
		logic                    redirect;
		rv_core_pkg::word_t      target;
		rv_core_pkg::sys_event_e sys;
	} test_entry_t;

	logic                    clock;
	logic                    reset;
	logic                    inst_valid;
	rv_core_pkg::word_t      inst;
	rv_core_pkg::word_t      pc;
	logic                    inst_ready;
	logic                    retire_valid;
	rv_core_pkg::writeback_t retire;
	logic                    redirect_valid;
	rv_core_pkg::word_t      redirect_pc;
	rv_core_pkg::sys_event_e sys_event;

	test_entry_t tests [NUM_TESTS];
	int          retire_q [$];
	int          redirect_q [$];
	int          sys_q [$];
	int          num_loaded;
	int          checks;
	int          mismatches;
	int          other_errors;
	logic [31:0] lfsr;

	rv_backend_top #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) i_dut (
		.clock, .reset, .inst_valid, .inst, .pc, .inst_ready, .retire_valid, .retire,
		.redirect_valid, .redirect_pc, .sys_event
	);

	function automatic rv_core_pkg::word_t r_type(input logic [6:0] op, input int rd,
			input int funct3, input int rs1, input int rs2);
		return {7'b0, 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), op};
	endfunction

	function automatic rv_core_pkg::word_t i_type(input logic [6:0] op, input int rd,
			input int funct3, input int rs1, input int imm);
		logic [31:0] v;
		v = 32'(imm);
		return {v[11:0], 5'(rs1), 3'(funct3), 5'(rd), op};
	endfunction

	function automatic rv_core_pkg::word_t s_type(input logic [6:0] op, input int funct3,
			input int rs1, input int rs2, input int imm);
		logic [31:0] v;
		v = 32'(imm);
		return {v[11:5], 5'(rs2), 5'(rs1), 3'(funct3), v[4:0], op};
	endfunction

	function automatic rv_core_pkg::word_t b_type(input logic [6:0] op, input int funct3,
			input int rs1, input int rs2, input int imm);
		logic [31:0] v;
		v = 32'(imm);
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(funct3), v[4:1], v[11], op};
	endfunction

	function automatic rv_core_pkg::word_t u_type(input logic [6:0] op, input int rd,
			input int imm);
		logic [31:0] v;
		v = 32'(imm);
		return {v[19:0], 5'(rd), op};
	endfunction

	function automatic rv_core_pkg::word_t j_type(input logic [6:0] op, input int rd,
			input int imm);
		logic [31:0] v;
		v = 32'(imm);
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), op};
	endfunction

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] next_lfsr(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic int find_entry(input rv_core_pkg::word_t target);
		for (int i = 0; i < NUM_TESTS; i++) begin
			if (tests[i].pc == target) begin
				return i;
			end
		end
		return -1;
	endfunction

	// Entries sit at consecutive word addresses from 0x100.
	task automatic add_test(input string name, input rv_core_pkg::word_t word, input logic wen,
			input int rd, input rv_core_pkg::word_t data, input logic redirect,
			input rv_core_pkg::word_t target, input rv_core_pkg::sys_event_e sys);
		tests[num_loaded] = '{name, 32'h100 + 32'(num_loaded * 4), word, wen, 4'(rd), data,
			redirect, target, sys};
		num_loaded++;
	endtask

	// Entries named skip_* lie on a taken path and must never retire.
	task automatic load_tests();
		add_test("addi_pos", i_type(OP_IMM, 1, 0, 0, 5), 1'b1, 1, 32'd5, 1'b0, 0, SYS_NONE);
		add_test("addi_neg", i_type(OP_IMM, 2, 0, 0, -12), 1'b1, 2, 32'hffff_fff4, 1'b0, 0,
			SYS_NONE);
		add_test("add_chain", r_type(OP_REG, 3, 0, 1, 2), 1'b1, 3, 32'hffff_fff9, 1'b0, 0,
			SYS_NONE);
		add_test("lui", u_type(OP_LUI, 4, 'h12345), 1'b1, 4, 32'h1234_5000, 1'b0, 0, SYS_NONE);
		add_test("auipc", u_type(OP_AUIPC, 5, 1), 1'b1, 5, 32'h0000_1110, 1'b0, 0, SYS_NONE);
		add_test("write_x0", i_type(OP_IMM, 0, 0, 1, 7), 1'b1, 0, 32'd12, 1'b0, 0, SYS_NONE);
		add_test("read_x0", r_type(OP_REG, 6, 0, 0, 1), 1'b1, 6, 32'd5, 1'b0, 0, SYS_NONE);
		add_test("addi_low", i_type(OP_IMM, 7, 0, 4, 'h678), 1'b1, 7, 32'h1234_5678, 1'b0, 0,
			SYS_NONE);
		add_test("addi_base", i_type(OP_IMM, 8, 0, 0, 64), 1'b1, 8, 32'h40, 1'b0, 0, SYS_NONE);
		add_test("sw_neg", s_type(OP_STORE, 2, 8, 7, -4), 1'b0, 0, 0, 1'b0, 0, SYS_NONE);
		add_test("lw_neg", i_type(OP_LOAD, 9, 2, 8, -4), 1'b1, 9, 32'h1234_5678, 1'b0, 0,
			SYS_NONE);
		add_test("load_use", r_type(OP_REG, 10, 0, 9, 1), 1'b1, 10, 32'h1234_567d, 1'b0, 0,
			SYS_NONE);
		add_test("sw_pos", s_type(OP_STORE, 2, 8, 3, 12), 1'b0, 0, 0, 1'b0, 0, SYS_NONE);
		add_test("lw_pos", i_type(OP_LOAD, 11, 2, 8, 12), 1'b1, 11, 32'hffff_fff9, 1'b0, 0,
			SYS_NONE);
		add_test("beq_taken", b_type(OP_BRANCH, 0, 1, 6, 12), 1'b0, 0, 0, 1'b1, 32'h144,
			SYS_NONE);
		add_test("skip_beq_a", i_type(OP_IMM, 12, 0, 0, 1), 1'b1, 12, 1, 1'b0, 0, SYS_NONE);
		add_test("skip_beq_b", i_type(OP_IMM, 12, 0, 0, 2), 1'b1, 12, 2, 1'b0, 0, SYS_NONE);
		add_test("beq_untaken", b_type(OP_BRANCH, 0, 1, 2, 8), 1'b0, 0, 0, 1'b0, 0, SYS_NONE);
		add_test("jal", j_type(OP_JAL, 13, 12), 1'b1, 13, 32'h14c, 1'b1, 32'h154, SYS_NONE);
		add_test("skip_jal_a", i_type(OP_IMM, 12, 0, 0, 3), 1'b1, 12, 3, 1'b0, 0, SYS_NONE);
		add_test("skip_jal_b", i_type(OP_IMM, 12, 0, 0, 4), 1'b1, 12, 4, 1'b0, 0, SYS_NONE);
		add_test("jalr_base", i_type(OP_IMM, 14, 0, 0, 'h160), 1'b1, 14, 32'h160, 1'b0, 0,
			SYS_NONE);
		// The odd sum 0x161 lands on 0x160 once bit 0 is cleared.
		add_test("jalr", i_type(OP_JALR, 15, 0, 14, 1), 1'b1, 15, 32'h15c, 1'b1, 32'h160,
			SYS_NONE);
		add_test("skip_jalr", i_type(OP_IMM, 12, 0, 0, 5), 1'b1, 12, 5, 1'b0, 0, SYS_NONE);
		add_test("ecall", 32'h0000_0073, 1'b0, 0, 0, 1'b0, 0, rv_core_pkg::sys_ecall);
		add_test("mret", 32'h3020_0073, 1'b0, 0, 0, 1'b0, 0, rv_core_pkg::sys_mret);
		add_test("fence_i", 32'h0000_100f, 1'b0, 0, 0, 1'b1, 32'h16c, SYS_NONE);
		add_test("skips_clean", i_type(OP_IMM, 12, 0, 12, 9), 1'b1, 12, 9, 1'b0, 0, SYS_NONE);
	endtask

	task automatic record_accept(input int idx);
		retire_q.push_back(idx);
		if (tests[idx].redirect) begin
			redirect_q.push_back(idx);
		end
		if (tests[idx].sys != SYS_NONE) begin
			sys_q.push_back(idx);
		end
	endtask

	task automatic show_mismatch(input string test, input string field,
			input rv_core_pkg::word_t expected, input rv_core_pkg::word_t actual);
		$display("MISMATCH %s %s expected %h actual %h", test, field, expected, actual);
		mismatches++;
	endtask

	task automatic check_outputs();
		int idx;
		if (retire_valid && retire_q.size() == 0) begin
			$display("ERROR: an instruction retired at %0t with none outstanding", $time);
			other_errors++;
		end else if (retire_valid) begin
			idx = retire_q.pop_front();
			checks++;
			assert (retire.wen == tests[idx].wen)
			else show_mismatch(tests[idx].name, "wen", 32'(tests[idx].wen), 32'(retire.wen));
			// Rd and data only carry meaning when the register is written.
			if (tests[idx].wen) begin
				assert (retire.rd == tests[idx].rd)
				else show_mismatch(tests[idx].name, "rd", 32'(tests[idx].rd), 32'(retire.rd));
				assert (retire.data == tests[idx].data)
				else show_mismatch(tests[idx].name, "data", tests[idx].data, retire.data);
			end
		end
		if (redirect_valid && redirect_q.size() == 0) begin
			$display("ERROR: a redirect to %h came from no branch or jump", redirect_pc);
			other_errors++;
		end else if (redirect_valid) begin
			idx = redirect_q.pop_front();
			checks++;
			assert (redirect_pc == tests[idx].target)
			else show_mismatch(tests[idx].name, "redirect_pc", tests[idx].target, redirect_pc);
		end
		if (sys_event != SYS_NONE && sys_q.size() == 0) begin
			$display("ERROR: a system event came from no ECALL or MRET");
			other_errors++;
		end else if (sys_event != SYS_NONE) begin
			idx = sys_q.pop_front();
			checks++;
			assert (sys_event == tests[idx].sys)
			else show_mismatch(tests[idx].name, "sys_event", 32'(tests[idx].sys), 32'(sys_event));
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
			other_errors);
		if (checks > 0 && mismatches == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(negedge clock) begin
		if (!reset) begin
			check_outputs();
		end
	end

	initial begin : front_end
		int idx;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		pc = '0;
		num_loaded = 0;
		checks = 0;
		mismatches = 0;
		other_errors = 0;
		lfsr = 32'ha5b59db0;
		load_tests();
		repeat (4) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		idx = 0;
		// One pass per cycle. A handshake seen at the falling edge completes on the next rise.
		while (idx < NUM_TESTS) begin
			lfsr = next_lfsr(lfsr);
			inst_valid = ~lfsr[0];
			inst = tests[idx].inst;
			pc = tests[idx].pc;
			@(negedge clock);
			if (redirect_valid) begin
				idx = find_entry(redirect_pc);
				if (idx < 0) begin
					$display("ERROR: redirect to %h has no table entry", redirect_pc);
					other_errors++;
					idx = NUM_TESTS;
				end
			end else if (inst_valid && inst_ready) begin
				record_accept(idx);
				idx++;
			end
			@(posedge clock);
			#DRIVE_DELAY;
		end
		inst_valid = 1'b0;
		while (retire_q.size() != 0) begin
			@(negedge clock);
		end
		repeat (MEM_LATENCY + 2) @(negedge clock);
		if (redirect_q.size() != 0 || sys_q.size() != 0) begin
			$display("ERROR: an expected redirect or system event never appeared");
			other_errors++;
		end
		report_and_finish();
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("ERROR: watchdog expired with %0d instructions still outstanding",
			retire_q.size());
		other_errors++;
		report_and_finish();
	end

endmodule

// ==== sim.f ====
rv_core_pkg.sv
register_file.sv
decode_stage.sv
execute_stage.sv
load_store_unit.sv
rv_backend_top.sv
tb_rv_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the backend testbench with Verilator, runs it and scans the log for a failure.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
	--top-module tb_rv_backend -f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_rv_backend > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
	exit 1
fi
exit 0
